//--- apb_temp_regs.sv
`timescale 1ns/10ps

module apb_temp_regs
    import temp_monitor_pkg::*;
(
    input  logic         clk_200kHz,
    input  logic         reset,
    input  apb_req_t     i_apb,
    output apb_rsp_t     o_apb,
    output logic         o_enable,
    output alarm_cfg_t   o_cfg,
    input  temp_sample_t i_sample,
    input  logic         i_sample_valid,
    input  logic         i_ack_error,
    input  logic [7:0]   i_degrees,
    input  logic         i_alarm
);

    logic        addr_ok;
    logic        access;       // APB access phase
    logic        wr_en;
    logic        ack_err;      // Sticky, write 1 to clear
    logic [7:0]  sample_cnt;
    logic [15:0] raw_q;

    always_comb begin
        case (i_apb.paddr)
            REG_CTRL, REG_STATUS, REG_TEMP, REG_THRESH: addr_ok = 1'b1;
            default:                                    addr_ok = 1'b0;
        endcase
    end

    assign access = i_apb.psel && i_apb.penable;
    assign wr_en  = access && i_apb.pwrite && addr_ok;   // Errored writes are dropped

    always_ff @(posedge clk_200kHz or posedge reset) begin
        if (reset) begin
            o_enable   <= 1'b0;
            o_cfg.high <= THRESH_HIGH_RST;
            o_cfg.low  <= THRESH_LOW_RST;
            ack_err    <= 1'b0;
            sample_cnt <= '0;
            raw_q      <= '0;
        end else begin
            if (i_sample_valid) begin
                sample_cnt <= sample_cnt + 1'b1;   // Free running, wraps
                raw_q      <= i_sample.raw;
            end

            // A new error wins over a clear in the same cycle
            if (i_ack_error)
                ack_err <= 1'b1;
            else if (wr_en && i_apb.paddr == REG_STATUS && i_apb.pwdata[1])
                ack_err <= 1'b0;

            if (wr_en) begin
                case (i_apb.paddr)
                    REG_CTRL: o_enable <= i_apb.pwdata[0];
                    REG_THRESH: begin
                        o_cfg.high <= i_apb.pwdata[7:0];
                        o_cfg.low  <= i_apb.pwdata[15:8];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data and response, zero wait states
    always_comb begin
        o_apb.prdata  = '0;
        o_apb.pready  = 1'b1;
        o_apb.pslverr = access && !addr_ok;
        case (i_apb.paddr)
            REG_CTRL:   o_apb.prdata[0]    = o_enable;
            REG_STATUS: o_apb.prdata[15:0] = {sample_cnt, 6'd0, ack_err, i_alarm};
            REG_TEMP:   o_apb.prdata[23:0] = {i_degrees, raw_q};
            REG_THRESH: o_apb.prdata[15:0] = {o_cfg.low, o_cfg.high};
            default:    o_apb.prdata       = '0;
        endcase
    end

    a_no_wait_states: assert property (@(posedge clk_200kHz) disable iff (reset)
        (i_apb.psel && i_apb.penable) |-> o_apb.pready);

endmodule

//--- i2c_temp_reader.sv
`timescale 1ns/10ps

module i2c_temp_reader
    import temp_monitor_pkg::*;
(
    input  logic         clk_200kHz,
    input  logic         reset,
    input  logic         i_enable,
    input  logic         i_sda_in,
    output logic         o_scl,
    output logic         o_sda_out,
    output logic         o_sda_oe,
    output temp_sample_t o_sample,
    output logic         o_sample_valid,
    output logic         o_ack_error
);

    logic [DIV_W-1:0]  div_cnt;
    logic [WAIT_W-1:0] wait_cnt;     // Power-up and gap timing
    logic [2:0]        bit_cnt;
    logic [15:0]       shift_reg;
    logic              ack_bad;      // Address ACK bit as sampled
    logic              scl_run;
    logic              tick;
    logic              mid;
    logic              mid_low;
    logic              mid_high;
    logic              fall;
    i2c_state_t        state;

    assign tick     = (div_cnt == DIV_W'(SCL_HALF_DIV - 1));
    assign mid      = (div_cnt == DIV_W'(SCL_HALF_DIV / 2 - 1));
    assign mid_low  = mid && !o_scl;   // Master updates SDA here
    assign mid_high = mid && o_scl;    // Sample point, START and STOP edges

    // SCL parks high while idle and in START until SDA has dropped
    assign scl_run = !(state inside {POWER_UP, GAP}) && !(state == START && o_sda_out);
    assign fall    = tick && scl_run && o_scl;

    always_ff @(posedge clk_200kHz or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            o_scl   <= 1'b1;
        end else begin
            if (tick) begin
                div_cnt <= '0;
                if (scl_run)
                    o_scl <= ~o_scl;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_200kHz or posedge reset) begin
        if (reset) begin
            state          <= POWER_UP;
            wait_cnt       <= '0;
            bit_cnt        <= '0;
            ack_bad        <= 1'b0;
            o_sda_out      <= 1'b1;
            o_sda_oe       <= 1'b0;
            o_sample_valid <= 1'b0;
            o_ack_error    <= 1'b0;
        end else begin
            o_sample_valid <= 1'b0;
            o_ack_error    <= 1'b0;
            case (state)
                POWER_UP: begin
                    if (wait_cnt == WAIT_W'(POWER_UP_CYCLES - 1)) begin
                        wait_cnt <= '0;
                        state    <= GAP;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                GAP: begin
                    if (wait_cnt != WAIT_W'(GAP_CYCLES - 1)) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end else if (i_enable) begin
                        o_sda_oe <= 1'b1;           // Master owns SDA from START on
                        state    <= START;
                    end
                end
                START: begin
                    if (mid_high) begin
                        o_sda_out <= 1'b0;          // START condition
                    end else if (fall) begin
                        bit_cnt <= 3'd7;
                        state   <= SEND_ADDR;
                    end
                end
                SEND_ADDR: begin
                    if (mid_low)
                        o_sda_out <= SENSOR_ADDR_RD[bit_cnt];
                    if (fall) begin
                        if (bit_cnt == 3'd0) begin
                            o_sda_oe <= 1'b0;       // Sensor drives the ACK bit
                            state    <= ADDR_ACK;
                        end
                        bit_cnt <= bit_cnt - 1'b1;  // Wraps to 7 for the data byte
                    end
                end
                ADDR_ACK: begin
                    if (mid_high)
                        ack_bad <= i_sda_in;
                    if (fall) begin
                        if (ack_bad) begin
                            o_ack_error <= 1'b1;
                            o_sda_oe    <= 1'b1;
                            state       <= STOP;
                        end else begin
                            state <= READ_MSB;
                        end
                    end
                end
                READ_MSB, READ_LSB: begin
                    if (fall) begin
                        if (bit_cnt == 3'd0) begin
                            o_sda_oe <= 1'b1;
                            state    <= (state == READ_MSB) ? MASTER_ACK : MASTER_NACK;
                        end
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                MASTER_ACK, MASTER_NACK: begin
                    if (mid_low)
                        o_sda_out <= (state == MASTER_NACK);  // ACK low, NACK high
                    if (fall) begin
                        o_sda_oe <= (state == MASTER_NACK);   // Kept for STOP
                        state    <= (state == MASTER_ACK) ? READ_LSB : STOP;
                    end
                end
                STOP: begin
                    if (mid_low) begin
                        o_sda_out <= 1'b0;
                    end else if (mid_high) begin
                        o_sda_out      <= 1'b1;     // STOP condition
                        o_sda_oe       <= 1'b0;
                        o_sample_valid <= !ack_bad;
                        wait_cnt       <= '0;
                        state          <= GAP;
                    end
                end
                default: begin
                    o_sda_oe <= 1'b0;
                    state    <= POWER_UP;
                end
            endcase
        end
    end

    // Both data bytes shift in MSB first
    always_ff @(posedge clk_200kHz) begin
        if (mid_high && (state == READ_MSB || state == READ_LSB))
            shift_reg <= {shift_reg[14:0], i_sda_in};
    end

    assign o_sample.raw = shift_reg;

    // The sensor owns SDA during its ACK and data bits
    a_sda_released: assert property (@(posedge clk_200kHz) disable iff (reset)
        (state inside {ADDR_ACK, READ_MSB, READ_LSB}) |-> !o_sda_oe);

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f temp_monitor_top.f \
    --top-module tb_temp_monitor -o sim_temp_monitor
./obj_dir/sim_temp_monitor > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

//--- tb_sensor_model.sv
`timescale 1ns/10ps

module tb_sensor_model (
    input  logic        i_scl,
    input  logic        i_sda_out,
    input  logic        i_sda_oe,
    input  logic [15:0] i_word,
    input  logic        i_silent,
    output logic        o_sda,
    output int          o_starts,
    output int          o_errors
);

    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic        in_frame = 1'b0;
    logic        acked    = 1'b0;
    logic        sda_q    = 1'b1;
    logic [7:0]  addr     = 8'h00;
    logic [15:0] data     = 16'h0000;
    int          n_rise   = 0;      // SCL rising edges since START
    int          starts_q = 0;
    int          errors_q = 0;

    assign o_sda    = sda_q;
    assign o_starts = starts_q;
    assign o_errors = errors_q;

    always @(i_scl or i_sda_out) begin
        if (i_scl && prev_scl && prev_sda && !i_sda_out && i_sda_oe) begin
            in_frame = 1'b1;                // START
            acked    = 1'b0;
            n_rise   = 0;
            starts_q = starts_q + 1;
        end else if (i_scl && prev_scl && !prev_sda && i_sda_out) begin
            in_frame = 1'b0;                // STOP
            sda_q    = 1'b1;
        end else if (in_frame && i_scl && !prev_scl) begin
            n_rise = n_rise + 1;
            if (n_rise <= 8)
                addr = {addr[6:0], i_sda_out};
            if (n_rise == 8 && addr != 8'h97) begin
                $display("Sensor model got address byte %h instead of 97 at %0t", addr, $time);
                errors_q = errors_q + 1;
            end
            if (acked && n_rise == 18 && !(i_sda_oe && !i_sda_out)) begin
                $display("Sensor model got no master ACK after the MSB at %0t", $time);
                errors_q = errors_q + 1;
            end
            if (acked && n_rise == 27 && !(i_sda_oe && i_sda_out)) begin
                $display("Sensor model got no master NACK after the LSB at %0t", $time);
                errors_q = errors_q + 1;
            end
        end else if (in_frame && !i_scl && prev_scl) begin
            if (n_rise == 8) begin
                acked = !i_silent;
                data  = i_word;
                sda_q = i_silent;           // ACK pulls low
            end else if (acked && ((n_rise >= 9 && n_rise <= 16) ||
                                   (n_rise >= 18 && n_rise <= 25))) begin
                sda_q = data[15];           // MSB first
                data  = {data[14:0], 1'b0};
            end else begin
                sda_q = 1'b1;
            end
        end
        prev_scl = i_scl;
        prev_sda = i_sda_out;
    end

endmodule

//--- tb_temp_monitor.sv
`timescale 1ns/10ps

module tb_temp_monitor;
    import temp_monitor_pkg::*;

    logic        clk_200kHz;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        sda_in;
    logic        sda_sensor;
    logic        alarm;
    logic [15:0] word;
    logic        silent;
    int          starts;
    int          model_errors;

    int          seed        = 54;
    int          checks      = 0;
    int          errors      = 0;
    logic        model_alarm = 1'b0;
    logic [7:0]  thr_high    = 8'd50;
    logic [7:0]  thr_low     = 8'd45;
    logic [7:0]  cnt         = 8'd0;   // Last sample count seen
    logic [31:0] rdata;

    assign sda_in = sda_sensor & (!sda_oe | sda_out);   // Open-drain bus

    temp_monitor_top i_temp_monitor_top (
        .clk_200kHz (clk_200kHz),
        .reset      (reset),
        .i_apb      (apb_req),
        .o_apb      (apb_rsp),
        .o_scl      (scl),
        .o_sda_out  (sda_out),
        .o_sda_oe   (sda_oe),
        .i_sda_in   (sda_in),
        .o_alarm    (alarm)
    );

    tb_sensor_model i_sensor (
        .i_scl     (scl),
        .i_sda_out (sda_out),
        .i_sda_oe  (sda_oe),
        .i_word    (word),
        .i_silent  (silent),
        .o_sda     (sda_sensor),
        .o_starts  (starts),
        .o_errors  (model_errors)
    );

    initial begin
        clk_200kHz = 1'b0;
        forever #5 clk_200kHz = ~clk_200kHz;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return next_random() % n;
    endfunction

    // Hysteresis rule for the alarm
    function automatic logic next_alarm(input logic prev, input logic [7:0] deg,
                                        input logic [7:0] hi, input logic [7:0] lo);
        if (deg >= hi)
            return 1'b1;
        if (deg < lo)
            return 1'b0;
        return prev;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              input logic exp_err, output logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk_200kHz);
        #1 apb_req.penable = 1'b1;
        #3 data = apb_rsp.prdata;
        check(32'(apb_rsp.pslverr), 32'(exp_err), $sformatf("pslverr at offset %0h", addr));
        check(32'(apb_rsp.pready), 32'd1, $sformatf("pready at offset %0h", addr));
        @(posedge clk_200kHz);
        #1 apb_req.psel = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic wait_step();
        int polls;
        polls = 0;
        apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        while (rdata[15:8] == cnt) begin
            polls++;
            if (polls > 2000)
                stop_on_timeout("the sample count in STATUS to step");
            apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        end
        check(32'(rdata[15:8]), 32'(8'(cnt + 8'd1)), "sample count step");
        cnt = rdata[15:8];
    endtask

    task automatic wait_ack_error();
        int polls;
        polls = 0;
        apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        while (!rdata[1]) begin
            polls++;
            if (polls > 2000)
                stop_on_timeout("the ACK error bit in STATUS");
            apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        end
    endtask

    task automatic take_sample(input logic [15:0] w);
        word = w;                               // Returned by the next transaction
        wait_step();
        apb_access(1'b0, REG_TEMP, 32'd0, 1'b0, rdata);
        check(rdata, {8'd0, w[14:7], w}, "TEMP register");
        model_alarm = next_alarm(model_alarm, w[14:7], thr_high, thr_low);
        apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        check(32'(rdata[0]), 32'(model_alarm), "STATUS alarm bit");
        check(32'(alarm), 32'(model_alarm), "o_alarm pin");
    endtask

    initial begin
        logic [15:0] w;
        logic [7:0]  deg;
        logic [3:0]  addr;
        logic [31:0] thr_val;
        logic [31:0] ctrl_val;
        logic        ctrl_en;
        logic [31:0] temp0;
        logic [7:0]  c0;
        int          s0;

        reset   = 1'b1;
        apb_req = '0;
        word    = 16'h0000;
        silent  = 1'b0;
        ctrl_en = 1'b1;
        repeat (3) @(posedge clk_200kHz);
        #1 reset = 1'b0;

        apb_access(1'b0, REG_CTRL, 32'd0, 1'b0, rdata);
        check(rdata, 32'd0, "CTRL after reset");
        apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        check(rdata, 32'd0, "STATUS after reset");
        apb_access(1'b0, REG_THRESH, 32'd0, 1'b0, rdata);
        check(rdata, 32'h0000_2D32, "THRESH after reset");
        check(32'(alarm), 32'd0, "o_alarm after reset");
        check(32'(scl), 32'd1, "SCL after reset");
        check(32'(sda_out), 32'd1, "SDA output after reset");
        check(32'(sda_oe), 32'd0, "SDA output enable after reset");
        repeat (POWER_UP_CYCLES + GAP_CYCLES + 200) @(posedge clk_200kHz);
        #1 check(starts, 32'd0, "START seen with enable off");
        $display("Test 1 reset state finished, %0d errors so far", errors);

        for (int i = 0; i < 20; i++) begin
            w = 16'(next_random());
            if (i == 0) begin
                word = w;
                apb_access(1'b1, REG_CTRL, 32'd1, 1'b0, rdata);
            end
            take_sample(w);
        end
        $display("Test 2 TEMP readback finished, %0d errors so far", errors);

        for (int i = 0; i < 20; i++) begin
            if (i % 5 == 0) begin
                thr_high = 8'(20 + rand_below(100));
                thr_low  = thr_high - 8'(rand_below(10));
                apb_access(1'b1, REG_THRESH, {16'd0, thr_low, thr_high}, 1'b0, rdata);
            end
            // Degrees a few steps around the band
            deg      = thr_low - 8'd6 + 8'(rand_below(32'(thr_high - thr_low) + 32'd13));
            w        = 16'(next_random());
            w[14:7]  = deg;
            take_sample(w);
        end
        $display("Test 3 alarm hysteresis finished, %0d errors so far", errors);

        silent = 1'b1;
        apb_access(1'b0, REG_TEMP, 32'd0, 1'b0, temp0);
        wait_ack_error();
        apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        check(32'(rdata[15:8]), 32'(cnt), "sample count after NACK");
        apb_access(1'b0, REG_TEMP, 32'd0, 1'b0, rdata);
        check(rdata, temp0, "TEMP after NACK");

        // Bus NACKs throughout, so no samples arrive here
        for (int i = 0; i < 8; i++) begin
            addr = 4'(next_random());
            if (addr[1:0] == 2'b00)
                addr[0] = 1'b1;
            apb_access(1'b1, addr, next_random(), 1'b1, rdata);
            apb_access(1'b0, addr, 32'd0, 1'b1, rdata);
            apb_access(1'b0, REG_THRESH, 32'd0, 1'b0, rdata);
            check(rdata, {16'd0, thr_low, thr_high}, "THRESH after unmapped write");
            apb_access(1'b0, REG_CTRL, 32'd0, 1'b0, rdata);
            check(rdata, {31'd0, ctrl_en}, "CTRL after unmapped write");
            thr_val = next_random();
            apb_access(1'b1, REG_THRESH, thr_val, 1'b0, rdata);
            thr_high = thr_val[7:0];
            thr_low  = thr_val[15:8];
            apb_access(1'b0, REG_THRESH, 32'd0, 1'b0, rdata);
            check(rdata, {16'd0, thr_val[15:0]}, "THRESH readback");
            ctrl_val = next_random();
            ctrl_en  = ctrl_val[0];
            apb_access(1'b1, REG_CTRL, ctrl_val, 1'b0, rdata);
            apb_access(1'b0, REG_CTRL, 32'd0, 1'b0, rdata);
            check(rdata, {31'd0, ctrl_en}, "CTRL readback");
        end
        apb_access(1'b1, REG_CTRL, 32'd1, 1'b0, rdata);
        $display("Test 5 register access finished, %0d errors so far", errors);

        // A fresh error means the next START is still a full gap away
        apb_access(1'b1, REG_STATUS, 32'd2, 1'b0, rdata);
        wait_ack_error();
        silent = 1'b0;
        apb_access(1'b1, REG_STATUS, 32'd2, 1'b0, rdata);
        apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        check(32'(rdata[1]), 32'd0, "ACK error bit after clear");
        check(32'(rdata[15:8]), 32'(cnt), "sample count across NACKs");
        take_sample(16'(next_random()));
        $display("Test 4 ACK error finished, %0d errors so far", errors);

        apb_access(1'b1, REG_CTRL, 32'd0, 1'b0, rdata);
        repeat (1500) @(posedge clk_200kHz);
        #1 apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        check(32'(rdata[15:8] - cnt <= 8'd1), 32'd1, "at most one sample after disable");
        c0 = rdata[15:8];
        s0 = starts;
        repeat (1500) @(posedge clk_200kHz);
        #1 apb_access(1'b0, REG_STATUS, 32'd0, 1'b0, rdata);
        check(32'(rdata[15:8]), 32'(c0), "sample count with enable off");
        check(starts, s0, "START seen with enable off");
        $display("Test 6 disable finished, %0d errors so far", errors);

        check(model_errors, 32'd0, "sensor model protocol errors");
        $display("Checks run: %0d, failed: %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- temp_alarm.sv
`timescale 1ns/10ps

module temp_alarm
    import temp_monitor_pkg::*;
(
    input  logic         clk_200kHz,
    input  logic         reset,
    input  temp_sample_t i_sample,
    input  logic         i_sample_valid,
    input  alarm_cfg_t   i_cfg,
    output logic [7:0]   o_degrees,
    output logic         o_alarm
);

    logic [7:0] new_degrees;

    // Whole degrees C sit in raw bits 14..7
    assign new_degrees = i_sample.raw[14:7];

    always_ff @(posedge clk_200kHz or posedge reset) begin
        if (reset) begin
            o_degrees <= '0;
            o_alarm   <= 1'b0;
        end else if (i_sample_valid) begin
            o_degrees <= new_degrees;
            if (new_degrees >= i_cfg.high)
                o_alarm <= 1'b1;
            else if (new_degrees < i_cfg.low)
                o_alarm <= 1'b0;
            // Between low and high the alarm holds its state
        end
    end

    // Alarm only moves on the edge right after a reading arrives
    a_alarm_on_sample: assert property (@(posedge clk_200kHz) disable iff (reset)
        $changed(o_alarm) |-> $past(i_sample_valid));

endmodule

//--- temp_monitor_pkg.sv
package temp_monitor_pkg;

    // I2C timing, in clk_200kHz cycles
    localparam int unsigned SCL_HALF_DIV    = 10;    // 200 kHz / (2 * 10) = 10 kHz SCL
    localparam int unsigned POWER_UP_CYCLES = 2000;  // Sensor settle time after reset
    localparam int unsigned GAP_CYCLES      = 40;    // Bus idle between STOP and START

    // Counter widths
    localparam int unsigned DIV_W  = $clog2(SCL_HALF_DIV);
    localparam int unsigned WAIT_W = $clog2(POWER_UP_CYCLES);

    localparam logic [7:0] SENSOR_ADDR_RD = 8'h97;   // 7-bit address 0x4B plus read bit

    // APB register offsets
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_TEMP   = 4'h8;
    localparam logic [3:0] REG_THRESH = 4'hC;

    // Threshold values out of reset, in degrees C
    localparam logic [7:0] THRESH_HIGH_RST = 8'd50;
    localparam logic [7:0] THRESH_LOW_RST  = 8'd45;

    typedef enum logic [3:0] {
        POWER_UP,
        GAP,
        START,
        SEND_ADDR,
        ADDR_ACK,
        READ_MSB,
        MASTER_ACK,
        READ_LSB,
        MASTER_NACK,
        STOP
    } i2c_state_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [15:0] raw;    // Sensor MSB in [15:8], LSB in [7:0]
    } temp_sample_t;

    typedef struct packed {
        logic [7:0] high;
        logic [7:0] low;
    } alarm_cfg_t;

endpackage

//--- temp_monitor_top.f
temp_monitor_pkg.sv
i2c_temp_reader.sv
temp_alarm.sv
apb_temp_regs.sv
temp_monitor_top.sv
tb_sensor_model.sv
tb_temp_monitor.sv

//--- temp_monitor_top.sv
`timescale 1ns/10ps

module temp_monitor_top
    import temp_monitor_pkg::*;
(
    input  logic     clk_200kHz,
    input  logic     reset,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb,
    output logic     o_scl,
    output logic     o_sda_out,
    output logic     o_sda_oe,    // Pad driver enable, the wrapper builds the open-drain pin
    input  logic     i_sda_in,
    output logic     o_alarm
);

    logic         enable;
    temp_sample_t sample;
    logic         sample_valid;
    logic         ack_error;
    alarm_cfg_t   cfg;
    logic [7:0]   degrees;

    i2c_temp_reader i_i2c_temp_reader (
        .clk_200kHz     (clk_200kHz),
        .reset          (reset),
        .i_enable       (enable),
        .i_sda_in       (i_sda_in),
        .o_scl          (o_scl),
        .o_sda_out      (o_sda_out),
        .o_sda_oe       (o_sda_oe),
        .o_sample       (sample),
        .o_sample_valid (sample_valid),
        .o_ack_error    (ack_error)
    );

    temp_alarm i_temp_alarm (
        .clk_200kHz     (clk_200kHz),
        .reset          (reset),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .i_cfg          (cfg),
        .o_degrees      (degrees),
        .o_alarm        (o_alarm)
    );

    apb_temp_regs i_apb_temp_regs (
        .clk_200kHz     (clk_200kHz),
        .reset          (reset),
        .i_apb          (i_apb),
        .o_apb          (o_apb),
        .o_enable       (enable),
        .o_cfg          (cfg),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .i_ack_error    (ack_error),
        .i_degrees      (degrees),
        .i_alarm        (o_alarm)
    );

endmodule
